// File: axi_id_serialize.f
hdl/axi_id_serialize_pkg.sv
hdl/ar_lane_demux.sv
hdl/id_serializer_lane.sv
hdl/ar_lane_arbiter.sv
hdl/axi_id_serialize.sv
bench/id_serializer_props.sv
bench/tb_axi_id_serialize.sv

// File: Bender.yml
package:
  name: axi_id_serialize

sources:
  # Design
  - hdl/axi_id_serialize_pkg.sv
  - hdl/ar_lane_demux.sv
  - hdl/id_serializer_lane.sv
  - hdl/ar_lane_arbiter.sv
  - hdl/axi_id_serialize.sv

  # Testbench
  - target: simulation
    files:
      - bench/id_serializer_props.sv
      - bench/tb_axi_id_serialize.sv

// File: bench/tb_axi_id_serialize.sv
/*
 * Testbench for the read-channel ID serializer. Random slave ARs, a memory
 * slave model on the master port, and in-order checks of AR and R traffic.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_axi_id_serialize;

  localparam int unsigned NumArs        = 400;
  localparam int unsigned TrafficCycles = 40000;
  localparam int unsigned DrainCycles   = 10000;
  localparam int unsigned NumLanes      = axi_id_serialize_pkg::NumLanes;

  logic                               clk_i;
  logic                               rst_n_i;
  axi_id_serialize_pkg::slv_ar_chan_t slv_ar;
  logic                               slv_ar_valid;
  logic                               slv_ar_ready;
  axi_id_serialize_pkg::slv_r_chan_t  slv_r;
  logic                               slv_r_valid;
  logic                               slv_r_ready;
  axi_id_serialize_pkg::mst_ar_chan_t mst_ar;
  logic                               mst_ar_valid;
  logic                               mst_ar_ready;
  axi_id_serialize_pkg::mst_r_chan_t  mst_r;
  logic                               mst_r_valid;
  logic                               mst_r_ready;

  // Accepted slave ARs in order, not yet seen at the master port
  axi_id_serialize_pkg::slv_ar_chan_t fwd_q [$];
  // Bursts still owed to the slave port, per lane
  axi_id_serialize_pkg::slv_ar_chan_t rsp_q [NumLanes][$];
  // Bursts the memory model still has to answer, per master ID
  axi_id_serialize_pkg::mst_ar_chan_t mem_q [NumLanes][$];
  axi_id_serialize_pkg::slv_id_t      last_sid [NumLanes];
  int unsigned mem_beat [NumLanes];
  int unsigned rsp_beat [NumLanes];
  int unsigned issued;
  int unsigned completed;
  int unsigned checks;
  int unsigned errors;
  // Handshakes seen at the falling edge, taken at the next rising edge
  bit          ar_taken;
  bit          r_taken;

  axi_id_serialize i_axi_id_serialize (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .slv_ar_i       ( slv_ar       ),
    .slv_ar_valid_i ( slv_ar_valid ),
    .slv_ar_ready_o ( slv_ar_ready ),
    .slv_r_o        ( slv_r        ),
    .slv_r_valid_o  ( slv_r_valid  ),
    .slv_r_ready_i  ( slv_r_ready  ),
    .mst_ar_o       ( mst_ar       ),
    .mst_ar_valid_o ( mst_ar_valid ),
    .mst_ar_ready_i ( mst_ar_ready ),
    .mst_r_i        ( mst_r        ),
    .mst_r_valid_i  ( mst_r_valid  ),
    .mst_r_ready_o  ( mst_r_ready  )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic report_error(input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    errors++;
  endtask

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else report_error(msg);
  endtask

  // New stimulus 1 ns after the rising edge; payloads held until taken
  task automatic drive_inputs(input bit allow_new);
    int unsigned start;
    int unsigned id;
    @(posedge clk_i);
    #1;
    if (ar_taken) begin
      slv_ar_valid = 1'b0;
    end
    if (!slv_ar_valid && allow_new && issued < NumArs && ($urandom % 4) != 0) begin
      // Three slave IDs share each lane
      slv_ar.id    = axi_id_serialize_pkg::slv_id_t'(($urandom % 3) * 32'h50 + ($urandom % 4));
      slv_ar.addr  = $urandom;
      slv_ar.len   = axi_id_serialize_pkg::len_t'($urandom % 8);
      slv_ar_valid = 1'b1;
    end
    slv_r_ready  = ($urandom % 3) != 0;
    mst_ar_ready = ($urandom % 4) != 0;
    if (r_taken) begin
      mst_r_valid = 1'b0;
    end
    if (!mst_r_valid && ($urandom % 4) != 0) begin
      start = $urandom % NumLanes;
      for (int unsigned k = 0; k < NumLanes; k++) begin
        id = (start + k) % NumLanes;
        if (!mst_r_valid && mem_q[id].size() != 0) begin
          mst_r.id    = axi_id_serialize_pkg::mst_id_t'(id);
          mst_r.data  = axi_id_serialize_pkg::data_t'(mem_q[id][0].addr + mem_beat[id]);
          mst_r.last  = (mem_beat[id] == mem_q[id][0].len);
          mst_r_valid = 1'b1;
        end
      end
    end
  endtask

  // Outputs are settled at the falling edge; transfers happen at the next rise
  task automatic sample_outputs();
    int unsigned ln;
    axi_id_serialize_pkg::slv_ar_chan_t exp_ar;
    @(negedge clk_i);
    ar_taken = slv_ar_valid && slv_ar_ready;
    r_taken  = mst_r_valid && mst_r_ready;
    if (r_taken) begin
      ln = mst_r.id;
      if (mst_r.last) begin
        void'(mem_q[ln].pop_front());
        mem_beat[ln] = 0;
      end else begin
        mem_beat[ln]++;
      end
    end
    if (mst_ar_valid && mst_ar_ready) begin
      ln = mst_ar.id;
      check_true(fwd_q.size() != 0, "master AR issued with no slave AR pending");
      if (fwd_q.size() != 0) begin
        exp_ar = fwd_q.pop_front();
        compare_field("mst_ar_o.id", mst_ar.id, exp_ar.id % NumLanes);
        compare_field("mst_ar_o.addr", mst_ar.addr, exp_ar.addr);
        compare_field("mst_ar_o.len", mst_ar.len, exp_ar.len);
        if (mem_q[ln].size() != 0) begin
          compare_field("serialized slave id", exp_ar.id, last_sid[ln]);
        end
        last_sid[ln] = exp_ar.id;
      end
      mem_q[ln].push_back(mst_ar);
      check_true(mem_q[ln].size() <= axi_id_serialize_pkg::MaxTxnsPerId,
                 "more bursts outstanding for one master ID than allowed");
    end
    if (ar_taken) begin
      fwd_q.push_back(slv_ar);
      rsp_q[slv_ar.id % NumLanes].push_back(slv_ar);
      issued++;
    end
    if (slv_r_valid && slv_r_ready) begin
      ln = slv_r.id % NumLanes;
      check_true(rsp_q[ln].size() != 0, "slave R beat arrived with no burst open");
      if (rsp_q[ln].size() != 0) begin
        exp_ar = rsp_q[ln][0];
        compare_field("slv_r_o.id", slv_r.id, exp_ar.id);
        compare_field("slv_r_o.data", slv_r.data,
                      axi_id_serialize_pkg::data_t'(exp_ar.addr + rsp_beat[ln]));
        compare_field("slv_r_o.last", slv_r.last, rsp_beat[ln] == exp_ar.len);
        if (rsp_beat[ln] == exp_ar.len) begin
          void'(rsp_q[ln].pop_front());
          rsp_beat[ln] = 0;
          completed++;
        end else begin
          rsp_beat[ln]++;
        end
      end
    end
  endtask

  initial begin
    int unsigned cyc;
    int unsigned err_base;
    void'($urandom(32'hdfd5));
    rst_n_i      = 1'b0;
    slv_ar       = '0;
    slv_ar_valid = 1'b0;
    slv_r_ready  = 1'b0;
    mst_ar_ready = 1'b0;
    mst_r        = '0;
    mst_r_valid  = 1'b0;
    issued       = 0;
    completed    = 0;
    checks       = 0;
    errors       = 0;
    ar_taken     = 1'b0;
    r_taken      = 1'b0;
    for (int unsigned i = 0; i < NumLanes; i++) begin
      mem_beat[i] = 0;
      rsp_beat[i] = 0;
      last_sid[i] = '0;
    end

    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    compare_field("mst_ar_valid_o", mst_ar_valid, 1'b0);
    compare_field("slv_r_valid_o", slv_r_valid, 1'b0);
    compare_field("slv_ar_ready_o", slv_ar_ready, 1'b0);
    $display("test reset_state finished, %0d errors", errors);

    err_base = errors;
    for (cyc = 0; cyc < TrafficCycles && issued < NumArs; cyc++) begin
      drive_inputs(1'b1);
      sample_outputs();
    end
    check_true(issued == NumArs, "traffic timed out before all ARs were accepted");
    $display("test random_traffic finished, %0d ARs, %0d errors", issued, errors - err_base);

    err_base = errors;
    for (cyc = 0; cyc < DrainCycles &&
         (completed != issued || slv_ar_valid || fwd_q.size() != 0); cyc++) begin
      drive_inputs(1'b0);
      sample_outputs();
    end
    check_true(completed == issued && fwd_q.size() == 0,
               "drain timed out with bursts still open");
    for (int unsigned i = 0; i < NumLanes; i++) begin
      check_true(mem_q[i].size() == 0, "memory model still holds bursts after drain");
    end
    $display("test drain finished, %0d bursts completed, %0d errors", completed,
             errors - err_base);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/id_serializer_props.sv
/*
 * Concurrent properties of a serializer lane, bound into every lane instance.
 */

`timescale 1ns/1ps
`default_nettype none

module id_serializer_props (
  input logic                          clk_i,
  input logic                          rst_n_i,
  input axi_id_serialize_pkg::cnt_t    cnt_i,
  input axi_id_serialize_pkg::slv_id_t id_i,
  input logic                          ar_valid_in_i,
  input logic                          ar_valid_out_i,
  input logic                          ar_ready_in_i
);

  cnt_within_limit: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    cnt_i <= axi_id_serialize_pkg::cnt_t'(axi_id_serialize_pkg::MaxTxnsPerId)
  ) else $error("lane burst counter above the per-ID limit");

  // The slave ID may only change once the lane has drained
  id_stable_while_open: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (cnt_i != '0) |=> $stable(id_i)
  ) else $error("lane slave ID changed while bursts were open");

  // A forwarded AR stays up, still backed by the demux, until the arbiter takes it
  valid_held_until_taken: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ar_valid_out_i && !ar_ready_in_i |=> ar_valid_out_i && ar_valid_in_i
  ) else $error("lane withdrew a forwarded AR before the arbiter took it");

endmodule

bind id_serializer_lane id_serializer_props i_id_serializer_props (
  .clk_i          ( clk_i      ),
  .rst_n_i        ( rst_n_i    ),
  .cnt_i          ( cnt_q      ),
  .id_i           ( id_q       ),
  .ar_valid_in_i  ( ar_valid_i ),
  .ar_valid_out_i ( ar_valid_o ),
  .ar_ready_in_i  ( ar_ready_i )
);

`default_nettype wire

// File: hdl/axi_id_serialize.sv
/*
 * Read-channel AXI ID serializer top. Maps 8-bit slave IDs onto 2-bit master
 * IDs through a demux, one serializer lane per master ID and an arbiter.
 */

`timescale 1ns/1ps
`default_nettype none

module axi_id_serialize (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  // Slave port
  input  axi_id_serialize_pkg::slv_ar_chan_t slv_ar_i,
  input  logic                               slv_ar_valid_i,
  output logic                               slv_ar_ready_o,
  output axi_id_serialize_pkg::slv_r_chan_t  slv_r_o,
  output logic                               slv_r_valid_o,
  input  logic                               slv_r_ready_i,
  // Master port
  output axi_id_serialize_pkg::mst_ar_chan_t mst_ar_o,
  output logic                               mst_ar_valid_o,
  input  logic                               mst_ar_ready_i,
  input  axi_id_serialize_pkg::mst_r_chan_t  mst_r_i,
  input  logic                               mst_r_valid_i,
  output logic                               mst_r_ready_o
);

  // Demux to lanes
  logic [axi_id_serialize_pkg::NumLanes-1:0]                              dmx_ar_valid;
  logic [axi_id_serialize_pkg::NumLanes-1:0]                              dmx_ar_ready;
  axi_id_serialize_pkg::slv_r_chan_t [axi_id_serialize_pkg::NumLanes-1:0] dmx_r;
  logic [axi_id_serialize_pkg::NumLanes-1:0]                              dmx_r_valid;
  logic [axi_id_serialize_pkg::NumLanes-1:0]                              dmx_r_ready;

  // Lanes to arbiter
  logic [axi_id_serialize_pkg::NumLanes-1:0] arb_ar_valid;
  logic [axi_id_serialize_pkg::NumLanes-1:0] arb_ar_ready;
  axi_id_serialize_pkg::mst_r_chan_t         arb_r;
  logic [axi_id_serialize_pkg::NumLanes-1:0] arb_r_valid;
  logic [axi_id_serialize_pkg::NumLanes-1:0] arb_r_ready;

  ar_lane_demux i_ar_lane_demux (
    .clk_i           ( clk_i          ),
    .rst_n_i         ( rst_n_i        ),
    .slv_ar_i        ( slv_ar_i       ),
    .slv_ar_valid_i  ( slv_ar_valid_i ),
    .slv_ar_ready_o  ( slv_ar_ready_o ),
    .slv_r_o         ( slv_r_o        ),
    .slv_r_valid_o   ( slv_r_valid_o  ),
    .slv_r_ready_i   ( slv_r_ready_i  ),
    .lane_ar_valid_o ( dmx_ar_valid   ),
    .lane_ar_ready_i ( dmx_ar_ready   ),
    .lane_r_i        ( dmx_r          ),
    .lane_r_valid_i  ( dmx_r_valid    ),
    .lane_r_ready_o  ( dmx_r_ready    )
  );

  for (genvar i = 0; i < axi_id_serialize_pkg::NumLanes; i++) begin : gen_lanes
    id_serializer_lane i_id_serializer_lane (
      .clk_i      ( clk_i           ),
      .rst_n_i    ( rst_n_i         ),
      .ar_i       ( slv_ar_i        ),
      .ar_valid_i ( dmx_ar_valid[i] ),
      .ar_ready_o ( dmx_ar_ready[i] ),
      .ar_valid_o ( arb_ar_valid[i] ),
      .ar_ready_i ( arb_ar_ready[i] ),
      .r_i        ( arb_r           ),
      .r_valid_i  ( arb_r_valid[i]  ),
      .r_ready_o  ( arb_r_ready[i]  ),
      .r_o        ( dmx_r[i]        ),
      .r_valid_o  ( dmx_r_valid[i]  ),
      .r_ready_i  ( dmx_r_ready[i]  )
    );
  end

  // Every lane forwards the slave AR payload unchanged
  ar_lane_arbiter i_ar_lane_arbiter (
    .clk_i           ( clk_i                                           ),
    .rst_n_i         ( rst_n_i                                         ),
    .lane_ar_i       ( {axi_id_serialize_pkg::NumLanes{slv_ar_i}}      ),
    .lane_ar_valid_i ( arb_ar_valid                                    ),
    .lane_ar_ready_o ( arb_ar_ready                                    ),
    .lane_r_o        ( arb_r                                           ),
    .lane_r_valid_o  ( arb_r_valid                                     ),
    .lane_r_ready_i  ( arb_r_ready                                     ),
    .mst_ar_o        ( mst_ar_o                                        ),
    .mst_ar_valid_o  ( mst_ar_valid_o                                  ),
    .mst_ar_ready_i  ( mst_ar_ready_i                                  ),
    .mst_r_i         ( mst_r_i                                         ),
    .mst_r_valid_i   ( mst_r_valid_i                                   ),
    .mst_r_ready_o   ( mst_r_ready_o                                   )
  );

endmodule

`default_nettype wire

// File: hdl/ar_lane_arbiter.sv
/*
 * Master side of the ID serializer. Round-robin AR arbitration over the lanes
 * into a two-entry spill register, lane index used as master ID; R by ID.
 */

`timescale 1ns/1ps
`default_nettype none

module ar_lane_arbiter (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  // Lane side
  input  axi_id_serialize_pkg::slv_ar_chan_t [axi_id_serialize_pkg::NumLanes-1:0] lane_ar_i,
  input  logic [axi_id_serialize_pkg::NumLanes-1:0] lane_ar_valid_i,
  output logic [axi_id_serialize_pkg::NumLanes-1:0] lane_ar_ready_o,
  output axi_id_serialize_pkg::mst_r_chan_t         lane_r_o,
  output logic [axi_id_serialize_pkg::NumLanes-1:0] lane_r_valid_o,
  input  logic [axi_id_serialize_pkg::NumLanes-1:0] lane_r_ready_i,
  // Master port
  output axi_id_serialize_pkg::mst_ar_chan_t        mst_ar_o,
  output logic                                      mst_ar_valid_o,
  input  logic                                      mst_ar_ready_i,
  input  axi_id_serialize_pkg::mst_r_chan_t         mst_r_i,
  input  logic                                      mst_r_valid_i,
  output logic                                      mst_r_ready_o
);

  axi_id_serialize_pkg::mst_id_t      rr_q;
  axi_id_serialize_pkg::mst_id_t      gnt_idx;
  logic                               gnt_found;
  axi_id_serialize_pkg::mst_ar_chan_t push_ar;
  axi_id_serialize_pkg::mst_ar_chan_t spill_q [2];
  logic                               wr_ptr_q;
  logic                               rd_ptr_q;
  logic [1:0]                         fill_q;
  logic                               spill_ready;
  logic                               push;
  logic                               pop;

  // First requesting lane at or after the round-robin pointer
  always_comb begin
    axi_id_serialize_pkg::mst_id_t idx;
    gnt_idx   = '0;
    gnt_found = 1'b0;
    for (int unsigned k = 0; k < axi_id_serialize_pkg::NumLanes; k++) begin
      idx = rr_q + axi_id_serialize_pkg::mst_id_t'(k);
      if (!gnt_found && lane_ar_valid_i[idx]) begin
        gnt_idx   = idx;
        gnt_found = 1'b1;
      end
    end
  end

  assign spill_ready = (fill_q != 2'd2);
  assign push        = gnt_found && spill_ready;
  assign pop         = mst_ar_valid_o && mst_ar_ready_i;

  always_comb begin
    for (int unsigned i = 0; i < axi_id_serialize_pkg::NumLanes; i++) begin
      lane_ar_ready_o[i] = push && (gnt_idx == axi_id_serialize_pkg::mst_id_t'(i));
    end
  end

  always_comb begin
    push_ar.id   = gnt_idx;
    push_ar.addr = lane_ar_i[gnt_idx].addr;
    push_ar.len  = lane_ar_i[gnt_idx].len;
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      spill_q[wr_ptr_q] <= push_ar;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      fill_q   <= 2'd0;
      rr_q     <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
        // Pointer moves past the lane just served
        rr_q     <= gnt_idx + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({push, pop})
        2'b10:   fill_q <= fill_q + 2'd1;
        2'b01:   fill_q <= fill_q - 2'd1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  assign mst_ar_valid_o = (fill_q != 2'd0);
  assign mst_ar_o       = spill_q[rd_ptr_q];

  // R beats go back to the lane named by the master ID
  assign lane_r_o = mst_r_i;

  always_comb begin
    for (int unsigned i = 0; i < axi_id_serialize_pkg::NumLanes; i++) begin
      lane_r_valid_o[i] = mst_r_valid_i &&
                          (mst_r_i.id == axi_id_serialize_pkg::mst_id_t'(i));
    end
  end

  assign mst_r_ready_o = lane_r_ready_i[mst_r_i.id];

endmodule

`default_nettype wire

// File: hdl/id_serializer_lane.sv
/*
 * One serializer lane. Lets a single slave ID through at a time, counts its
 * open bursts and puts the stored slave ID back onto the read beats.
 */

`timescale 1ns/1ps
`default_nettype none

module id_serializer_lane (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  // AR from the demux
  input  axi_id_serialize_pkg::slv_ar_chan_t ar_i,
  input  logic                               ar_valid_i,
  output logic                               ar_ready_o,
  // AR towards the arbiter, payload is ar_i itself
  output logic                               ar_valid_o,
  input  logic                               ar_ready_i,
  // R from the arbiter
  input  axi_id_serialize_pkg::mst_r_chan_t  r_i,
  input  logic                               r_valid_i,
  output logic                               r_ready_o,
  // R towards the demux
  output axi_id_serialize_pkg::slv_r_chan_t  r_o,
  output logic                               r_valid_o,
  input  logic                               r_ready_i
);

  axi_id_serialize_pkg::slv_id_t id_q;
  axi_id_serialize_pkg::cnt_t    cnt_q;
  logic                          id_match;
  logic                          below_max;
  logic                          admit;
  logic                          ar_fire;
  logic                          r_last_fire;

  assign id_match  = (ar_i.id == id_q);
  assign below_max = cnt_q <
                     axi_id_serialize_pkg::cnt_t'(axi_id_serialize_pkg::MaxTxnsPerId);

  // An idle lane takes any ID, a busy one only more of the same ID
  assign admit = (cnt_q == '0) || (id_match && below_max);

  assign ar_valid_o = ar_valid_i && admit;
  assign ar_ready_o = ar_ready_i && admit;

  assign ar_fire     = ar_valid_o && ar_ready_i;
  assign r_last_fire = r_valid_i && r_ready_o && r_i.last;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      case ({ar_fire, r_last_fire})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Only rewritten on acceptance, so it holds while bursts are open
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_q <= '0;
    end else if (ar_fire) begin
      id_q <= ar_i.id;
    end
  end

  // Responses pass straight through with the slave ID restored
  always_comb begin
    r_o.id   = id_q;
    r_o.data = r_i.data;
    r_o.last = r_i.last;
  end

  assign r_valid_o = r_valid_i;
  assign r_ready_o = r_ready_i;

endmodule

`default_nettype wire

// File: hdl/ar_lane_demux.sv
/*
 * Slave side of the ID serializer. Steers each AR to the lane picked by the
 * low ID bits and merges the lane R beats back onto the slave port.
 */

`timescale 1ns/1ps
`default_nettype none

module ar_lane_demux (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  // Slave port
  input  axi_id_serialize_pkg::slv_ar_chan_t                     slv_ar_i,
  input  logic                                                   slv_ar_valid_i,
  output logic                                                   slv_ar_ready_o,
  output axi_id_serialize_pkg::slv_r_chan_t                      slv_r_o,
  output logic                                                   slv_r_valid_o,
  input  logic                                                   slv_r_ready_i,
  // Lane side
  output logic [axi_id_serialize_pkg::NumLanes-1:0]              lane_ar_valid_o,
  input  logic [axi_id_serialize_pkg::NumLanes-1:0]              lane_ar_ready_i,
  input  axi_id_serialize_pkg::slv_r_chan_t [axi_id_serialize_pkg::NumLanes-1:0] lane_r_i,
  input  logic [axi_id_serialize_pkg::NumLanes-1:0]              lane_r_valid_i,
  output logic [axi_id_serialize_pkg::NumLanes-1:0]              lane_r_ready_o
);

  axi_id_serialize_pkg::mst_id_t lane_sel;
  logic                          ready_q;

  // Lane index is the slave ID modulo the lane count
  assign lane_sel = slv_ar_i.id[axi_id_serialize_pkg::MstIdWidth-1:0];

  // Slave port stays closed for the first cycle out of reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b1;
    end
  end

  always_comb begin
    for (int unsigned i = 0; i < axi_id_serialize_pkg::NumLanes; i++) begin
      lane_ar_valid_o[i] = slv_ar_valid_i && ready_q &&
                           (lane_sel == axi_id_serialize_pkg::mst_id_t'(i));
    end
  end

  assign slv_ar_ready_o = ready_q && lane_ar_ready_i[lane_sel];

  // At most one lane carries a beat, so an OR over the valid lanes selects it
  always_comb begin
    slv_r_o = '0;
    for (int unsigned i = 0; i < axi_id_serialize_pkg::NumLanes; i++) begin
      if (lane_r_valid_i[i]) begin
        slv_r_o = axi_id_serialize_pkg::slv_r_chan_t'(slv_r_o | lane_r_i[i]);
      end
    end
  end

  assign slv_r_valid_o  = |lane_r_valid_i;
  assign lane_r_ready_o = lane_r_valid_i & {axi_id_serialize_pkg::NumLanes{slv_r_ready_i}};

endmodule

`default_nettype wire

// File: hdl/axi_id_serialize_pkg.sv
/*
 * Shared widths, counts and AXI read channel types of the ID serializer.
 * RTL and bench refer to everything here by package-scoped names.
 */

`default_nettype none

package axi_id_serialize_pkg;

  // Slave and master ID spaces
  localparam int unsigned SlvIdWidth = 8;
  localparam int unsigned NumLanes   = 4;
  localparam int unsigned MstIdWidth = $clog2(NumLanes);

  // Bursts a lane may keep in flight for its current slave ID
  localparam int unsigned MaxTxnsPerId = 4;
  localparam int unsigned CntWidth     = $clog2(MaxTxnsPerId + 1);

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned LenWidth  = 8;

  typedef logic [SlvIdWidth-1:0] slv_id_t;
  typedef logic [MstIdWidth-1:0] mst_id_t;
  typedef logic [AddrWidth-1:0]  addr_t;
  typedef logic [DataWidth-1:0]  data_t;
  typedef logic [LenWidth-1:0]   len_t;
  typedef logic [CntWidth-1:0]   cnt_t;

  // AR at the slave port, also used between demux, lanes and arbiter
  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
  } slv_ar_chan_t;

  // AR at the master port, id is the lane index
  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } mst_ar_chan_t;

  // R beat carrying the restored slave ID
  typedef struct packed {
    slv_id_t id;
    data_t   data;
    logic    last;
  } slv_r_chan_t;

  // R beat as returned by the master port
  typedef struct packed {
    mst_id_t id;
    data_t   data;
    logic    last;
  } mst_r_chan_t;

endpackage

`default_nettype wire
